// File: source/jtag_pkg.sv
// jtag tap package with state encoding, opcodes and identification word layout.
package jtag_pkg;

	// --------------------
	// tap state encoding with reset at zero.
	typedef enum logic [3:0] {
		TEST_LOGIC_RESET = 4'd0,
		RUN_TEST_IDLE    = 4'd1,
		SELECT_DR_SCAN   = 4'd2,
		CAPTURE_DR       = 4'd3,
		SHIFT_DR         = 4'd4,
		EXIT1_DR         = 4'd5,
		PAUSE_DR         = 4'd6,
		EXIT2_DR         = 4'd7,
		UPDATE_DR        = 4'd8,
		SELECT_IR_SCAN   = 4'd9,
		CAPTURE_IR       = 4'd10,
		SHIFT_IR         = 4'd11,
		EXIT1_IR         = 4'd12,
		PAUSE_IR         = 4'd13,
		EXIT2_IR         = 4'd14,
		UPDATE_IR        = 4'd15
	} tap_state_e;

	// --------------------
	localparam int IR_WIDTH = 4;

	// any code not listed selects bypass.
	typedef enum logic [IR_WIDTH-1:0] {
		INSTR_IDCODE    = 4'b0001,
		INSTR_USER_DATA = 4'b0010,
		INSTR_BYPASS    = 4'b1111
	} instr_e;

	localparam logic [IR_WIDTH-1:0] IR_CAPTURE = 4'b0101; // lsbs 01 per standard.

	// --------------------
	typedef struct packed {
		logic [3:0]  version;
		logic [15:0] part_number;
		logic [10:0] manufacturer;
		logic        marker; // always 1.
	} idcode_fields_t;

	typedef union packed {
		logic [31:0]    raw;
		idcode_fields_t fields;
	} idcode_u;

endpackage

// File: source/tap_controller.sv
// tap controller, sixteen-state fsm on tck steered by tms with decoded strobes.
`timescale 1ns/1ps

module tap_controller (
	input  logic                 TCK,
	input  logic                 rst,
	input  logic                 tms,
	output jtag_pkg::tap_state_e tap_state,
	output logic                 capture_dr,
	output logic                 shift_dr,
	output logic                 update_dr,
	output logic                 capture_ir,
	output logic                 shift_ir,
	output logic                 update_ir,
	output logic                 in_reset
);

	jtag_pkg::tap_state_e state;
	jtag_pkg::tap_state_e next_state;

	// --------------------
	always_ff @(posedge TCK) begin
		if (rst)
			state <= jtag_pkg::TEST_LOGIC_RESET;
		else
			state <= next_state;
	end

	// --------------------
	// standard transition table.
	always_comb begin
		next_state = jtag_pkg::TEST_LOGIC_RESET;
		case (state)
			jtag_pkg::TEST_LOGIC_RESET:
				next_state = tms ? jtag_pkg::TEST_LOGIC_RESET : jtag_pkg::RUN_TEST_IDLE;
			jtag_pkg::RUN_TEST_IDLE:
				next_state = tms ? jtag_pkg::SELECT_DR_SCAN : jtag_pkg::RUN_TEST_IDLE;
			jtag_pkg::SELECT_DR_SCAN:
				next_state = tms ? jtag_pkg::SELECT_IR_SCAN : jtag_pkg::CAPTURE_DR;
			jtag_pkg::CAPTURE_DR:
				next_state = tms ? jtag_pkg::EXIT1_DR : jtag_pkg::SHIFT_DR;
			jtag_pkg::SHIFT_DR:
				next_state = tms ? jtag_pkg::EXIT1_DR : jtag_pkg::SHIFT_DR;
			jtag_pkg::EXIT1_DR:
				next_state = tms ? jtag_pkg::UPDATE_DR : jtag_pkg::PAUSE_DR;
			jtag_pkg::PAUSE_DR:
				next_state = tms ? jtag_pkg::EXIT2_DR : jtag_pkg::PAUSE_DR;
			jtag_pkg::EXIT2_DR:
				next_state = tms ? jtag_pkg::UPDATE_DR : jtag_pkg::SHIFT_DR;
			jtag_pkg::UPDATE_DR:
				next_state = tms ? jtag_pkg::SELECT_DR_SCAN : jtag_pkg::RUN_TEST_IDLE;
			jtag_pkg::SELECT_IR_SCAN:
				next_state = tms ? jtag_pkg::TEST_LOGIC_RESET : jtag_pkg::CAPTURE_IR;
			jtag_pkg::CAPTURE_IR:
				next_state = tms ? jtag_pkg::EXIT1_IR : jtag_pkg::SHIFT_IR;
			jtag_pkg::SHIFT_IR:
				next_state = tms ? jtag_pkg::EXIT1_IR : jtag_pkg::SHIFT_IR;
			jtag_pkg::EXIT1_IR:
				next_state = tms ? jtag_pkg::UPDATE_IR : jtag_pkg::PAUSE_IR;
			jtag_pkg::PAUSE_IR:
				next_state = tms ? jtag_pkg::EXIT2_IR : jtag_pkg::PAUSE_IR;
			jtag_pkg::EXIT2_IR:
				next_state = tms ? jtag_pkg::UPDATE_IR : jtag_pkg::SHIFT_IR;
			jtag_pkg::UPDATE_IR:
				next_state = tms ? jtag_pkg::SELECT_DR_SCAN : jtag_pkg::RUN_TEST_IDLE;
			default:
				next_state = jtag_pkg::TEST_LOGIC_RESET;
		endcase
	end

	// --------------------
	// moore strobes from the registered state.
	assign tap_state  = state;
	assign capture_dr = (state == jtag_pkg::CAPTURE_DR);
	assign shift_dr   = (state == jtag_pkg::SHIFT_DR);
	assign update_dr  = (state == jtag_pkg::UPDATE_DR);
	assign capture_ir = (state == jtag_pkg::CAPTURE_IR);
	assign shift_ir   = (state == jtag_pkg::SHIFT_IR);
	assign update_ir  = (state == jtag_pkg::UPDATE_IR);
	assign in_reset   = (state == jtag_pkg::TEST_LOGIC_RESET);

endmodule

// File: source/instruction_register.sv
// instruction register with capture pattern, shift stage and latched instruction.
`timescale 1ns/1ps

module instruction_register (
	input  logic             TCK,
	input  logic             rst,
	input  logic             tdi,
	input  logic             in_reset,
	input  logic             capture_ir,
	input  logic             shift_ir,
	input  logic             update_ir,
	output jtag_pkg::instr_e instruction,
	output logic             ir_tdo,
	output logic             ir_shift
);

	logic [jtag_pkg::IR_WIDTH-1:0] ir_chain;
	jtag_pkg::instr_e              ir_latch;

	// --------------------
	// shift stage, lsb first toward tdo.
	always_ff @(posedge TCK) begin
		if (capture_ir)
			ir_chain <= jtag_pkg::IR_CAPTURE;
		else if (shift_ir)
			ir_chain <= {tdi, ir_chain[jtag_pkg::IR_WIDTH-1:1]};
	end

	// --------------------
	// current instruction, idcode out of reset.
	always_ff @(posedge TCK) begin
		if (rst || in_reset)
			ir_latch <= jtag_pkg::INSTR_IDCODE;
		else if (update_ir)
			ir_latch <= jtag_pkg::instr_e'(ir_chain);
	end

	assign instruction = ir_latch;
	assign ir_tdo      = ir_chain[0];
	assign ir_shift    = shift_ir; // lets the data path pick the ir chain.

endmodule

// File: source/data_path.sv
// jtag data registers: bypass, idcode and user chains with falling-edge tdo.
`timescale 1ns/1ps

module data_path #(
	parameter jtag_pkg::idcode_u IDCODE_VALUE = 32'h1B36_E0C3,
	parameter int                USER_WIDTH   = 8
) (
	input  logic                  TCK,
	input  logic                  rst,
	input  logic                  tdi,
	input  logic                  capture_dr,
	input  logic                  shift_dr,
	input  logic                  update_dr,
	input  logic                  ir_tdo,
	input  logic                  ir_shift,
	input  jtag_pkg::instr_e      instruction,
	output logic                  tdo,
	output logic                  tdo_en,
	output logic                  user_update,
	output logic [USER_WIDTH-1:0] user_data
);

	logic                  bypass_chain;
	logic [31:0]           id_chain;
	logic [USER_WIDTH-1:0] user_chain;
	logic                  sel_idcode;
	logic                  sel_user;
	logic                  dr_tdo;

	assign sel_idcode = (instruction == jtag_pkg::INSTR_IDCODE);
	assign sel_user   = (instruction == jtag_pkg::INSTR_USER_DATA);

	// --------------------
	// scan chains, only the selected one moves.
	always_ff @(posedge TCK) begin
		if (!sel_idcode && !sel_user) begin
			if (capture_dr)
				bypass_chain <= 1'b0;
			else if (shift_dr)
				bypass_chain <= tdi;
		end
	end

	always_ff @(posedge TCK) begin
		if (sel_idcode) begin
			if (capture_dr)
				id_chain <= IDCODE_VALUE.raw;
			else if (shift_dr)
				id_chain <= {tdi, id_chain[31:1]};
		end
	end

	always_ff @(posedge TCK) begin
		if (sel_user) begin
			if (capture_dr)
				user_chain <= user_data; // read back last write.
			else if (shift_dr)
				user_chain <= {tdi, user_chain[USER_WIDTH-1:1]};
		end
	end

	// --------------------
	// parallel user register.
	always_ff @(posedge TCK) begin
		if (rst)
			user_data <= '0;
		else if (user_update)
			user_data <= user_chain;
	end

	assign user_update = update_dr && sel_user;

	// --------------------
	always_comb begin
		if (sel_idcode)
			dr_tdo = id_chain[0];
		else if (sel_user)
			dr_tdo = user_chain[0];
		else
			dr_tdo = bypass_chain;
	end

	// tdo changes on the falling edge, held low outside shift.
	always_ff @(negedge TCK) begin
		if (rst) begin
			tdo    <= 1'b0;
			tdo_en <= 1'b0;
		end else begin
			tdo_en <= ir_shift || shift_dr;
			if (ir_shift)
				tdo <= ir_tdo;
			else if (shift_dr)
				tdo <= dr_tdo;
			else
				tdo <= 1'b0;
		end
	end

endmodule

// File: source/jtag_tap.sv
// jtag test access port top, controller plus instruction and data registers.
`timescale 1ns/1ps

module jtag_tap #(
	parameter jtag_pkg::idcode_u IDCODE_VALUE = 32'h1B36_E0C3,
	parameter int                USER_WIDTH   = 8
) (
	input  logic                  TCK,
	input  logic                  rst,
	input  logic                  tms,
	input  logic                  tdi,
	output logic                  tdo,
	output logic                  tdo_en,
	output logic                  user_update,
	output jtag_pkg::tap_state_e  tap_state,
	output jtag_pkg::instr_e      instruction,
	output logic [USER_WIDTH-1:0] user_data
);

	logic capture_dr;
	logic shift_dr;
	logic update_dr;
	logic capture_ir;
	logic shift_ir;
	logic update_ir;
	logic in_reset;
	logic ir_tdo;
	logic ir_shift;

	// --------------------
	tap_controller u_tap_controller (
		.TCK        (TCK),
		.rst        (rst),
		.tms        (tms),
		.tap_state  (tap_state),
		.capture_dr (capture_dr),
		.shift_dr   (shift_dr),
		.update_dr  (update_dr),
		.capture_ir (capture_ir),
		.shift_ir   (shift_ir),
		.update_ir  (update_ir),
		.in_reset   (in_reset)
	);

	instruction_register u_instruction_register (
		.TCK         (TCK),
		.rst         (rst),
		.tdi         (tdi),
		.in_reset    (in_reset),
		.capture_ir  (capture_ir),
		.shift_ir    (shift_ir),
		.update_ir   (update_ir),
		.instruction (instruction),
		.ir_tdo      (ir_tdo),
		.ir_shift    (ir_shift)
	);

	data_path #(
		.IDCODE_VALUE (IDCODE_VALUE),
		.USER_WIDTH   (USER_WIDTH)
	) u_data_path (
		.TCK         (TCK),
		.rst         (rst),
		.tdi         (tdi),
		.capture_dr  (capture_dr),
		.shift_dr    (shift_dr),
		.update_dr   (update_dr),
		.ir_tdo      (ir_tdo),
		.ir_shift    (ir_shift),
		.instruction (instruction),
		.tdo         (tdo),
		.tdo_en      (tdo_en),
		.user_update (user_update),
		.user_data   (user_data)
	);

endmodule

// File: testbench/tap_controller_assertions.sv
// concurrent checks on tap controller reset and shift entry paths.
`timescale 1ns/1ps

module tap_controller_assertions (
	input logic                 TCK,
	input logic                 rst,
	input logic                 tms,
	input jtag_pkg::tap_state_e tap_state
);

	// --------------------
	assert property (@(posedge TCK) disable iff (rst)
		(tms && $past(tms, 1) && $past(tms, 2) && $past(tms, 3) && $past(tms, 4))
		|=> (tap_state == jtag_pkg::TEST_LOGIC_RESET))
		else $error("five tms-high edges did not reach test_logic_reset");

	assert property (@(posedge TCK) disable iff (rst)
		(tap_state == jtag_pkg::SHIFT_DR) |->
		($past(tap_state) inside {jtag_pkg::CAPTURE_DR, jtag_pkg::SHIFT_DR, jtag_pkg::EXIT2_DR}))
		else $error("shift_dr entered from an illegal state");

	assert property (@(posedge TCK) disable iff (rst)
		(tap_state == jtag_pkg::SHIFT_IR) |->
		($past(tap_state) inside {jtag_pkg::CAPTURE_IR, jtag_pkg::SHIFT_IR, jtag_pkg::EXIT2_IR}))
		else $error("shift_ir entered from an illegal state");

endmodule

bind tap_controller tap_controller_assertions u_tap_controller_assertions (
	.TCK       (TCK),
	.rst       (rst),
	.tms       (tms),
	.tap_state (tap_state)
);

// File: testbench/tb_jtag_tap.sv
// testbench for the jtag tap with directed scans checked against a state model.
`timescale 1ns/1ps

module tb_jtag_tap;

	localparam int USER_WIDTH    = 8;
	localparam int CLK_PERIOD    = 100;
	localparam int TEST_CYCLES   = 370; // reset, walk and all scans.
	localparam int MARGIN_CYCLES = 100;
	localparam jtag_pkg::idcode_u TB_IDCODE = 32'h3C59_A1E5;

	logic                  TCK;
	logic                  rst;
	logic                  tms;
	logic                  tdi;
	logic                  tdo;
	logic                  tdo_en;
	logic                  user_update;
	jtag_pkg::tap_state_e  tap_state;
	jtag_pkg::instr_e      instruction;
	logic [USER_WIDTH-1:0] user_data;

	jtag_pkg::tap_state_e  model_state;
	logic [USER_WIDTH-1:0] user_expect;
	int                    seed = 45409;
	int                    pulse_count;

	// next state by state code for tms low and tms high.
	logic [3:0] next_on_low [16] = '{4'd1, 4'd1, 4'd3, 4'd4, 4'd4, 4'd6, 4'd6, 4'd4,
		4'd1, 4'd10, 4'd11, 4'd11, 4'd13, 4'd13, 4'd11, 4'd1};
	logic [3:0] next_on_high [16] = '{4'd0, 4'd2, 4'd9, 4'd5, 4'd5, 4'd8, 4'd7, 4'd8,
		4'd2, 4'd0, 4'd12, 4'd12, 4'd15, 4'd14, 4'd15, 4'd2};

	jtag_tap #(
		.IDCODE_VALUE (TB_IDCODE),
		.USER_WIDTH   (USER_WIDTH)
	) DUT (
		.TCK         (TCK),
		.rst         (rst),
		.tms         (tms),
		.tdi         (tdi),
		.tdo         (tdo),
		.tdo_en      (tdo_en),
		.user_update (user_update),
		.tap_state   (tap_state),
		.instruction (instruction),
		.user_data   (user_data)
	);

	initial begin
		TCK = 1'b0;
		forever #(CLK_PERIOD / 2) TCK = ~TCK;
	end

	initial begin
		#((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
		$display("watchdog expired, tests did not finish in %0d cycles",
			TEST_CYCLES + MARGIN_CYCLES);
		$display("Simulation failed");
		$fatal(1);
	end

	// --------------------
	task automatic report_mismatch(input string msg);
		$display("ERROR at %0d ns: %s", $time, msg);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic compare_state(input jtag_pkg::tap_state_e got, input jtag_pkg::tap_state_e exp);
		if (got !== exp)
			report_mismatch($sformatf("tap_state %s, expected %s", got.name(), exp.name()));
	endtask

	task automatic compare_instr(input jtag_pkg::instr_e got, input jtag_pkg::instr_e exp);
		if (got !== exp)
			report_mismatch($sformatf("instruction %h, expected %h", got, exp));
	endtask

	task automatic compare_idcode(input jtag_pkg::idcode_u got, input jtag_pkg::idcode_u exp);
		if (got.raw !== exp.raw)
			report_mismatch($sformatf("idcode raw %h, expected %h", got.raw, exp.raw));
		// fields of 3C59_A1E5.
		if (got.fields.version !== 4'h3 || got.fields.part_number !== 16'hC59A ||
				got.fields.manufacturer !== 11'h0F2 || got.fields.marker !== 1'b1)
			report_mismatch($sformatf("idcode fields wrong in %h", got.raw));
	endtask

	task automatic compare_ir(input logic [jtag_pkg::IR_WIDTH-1:0] got,
			input logic [jtag_pkg::IR_WIDTH-1:0] exp);
		if (got !== exp)
			report_mismatch($sformatf("ir capture %b, expected %b", got, exp));
	endtask

	task automatic compare_bits(input logic [USER_WIDTH-1:0] got,
			input logic [USER_WIDTH-1:0] exp, input string what);
		if (got !== exp)
			report_mismatch($sformatf("%s %h, expected %h", what, got, exp));
	endtask

	task automatic compare_flag(input logic got, input logic exp, input string what);
		if (got !== exp)
			report_mismatch($sformatf("%s %b, expected %b", what, got, exp));
	endtask

	// --------------------
	task automatic apply_reset();
		@(negedge TCK);
		rst = 1'b1;
		tms = 1'b1;
		repeat (10) @(negedge TCK);
		rst = 1'b0;
		@(posedge TCK);
		#1;
		model_state = jtag_pkg::TEST_LOGIC_RESET;
	endtask

	task automatic clock_bit(input logic t, input logic d, output logic sampled);
		@(negedge TCK);
		tms = t;
		tdi = d;
		@(posedge TCK);
		sampled = tdo; // set at the last falling edge.
		model_state = jtag_pkg::tap_state_e'(t ? next_on_high[model_state] : next_on_low[model_state]);
		#1;
		compare_state(tap_state, model_state);
		if (user_update)
			pulse_count++;
	endtask

	task automatic tms_step(input logic t);
		logic ignored;
		clock_bit(t, 1'b0, ignored);
	endtask

	task automatic shift_ir(input logic [jtag_pkg::IR_WIDTH-1:0] code,
			output logic [jtag_pkg::IR_WIDTH-1:0] captured);
		logic [jtag_pkg::IR_WIDTH-1:0] bits;
		logic                          sampled;
		bits = code;
		captured = '0;
		tms_step(1'b1);
		tms_step(1'b1);
		tms_step(1'b0);
		tms_step(1'b0);
		for (int i = 0; i < jtag_pkg::IR_WIDTH; i++) begin
			clock_bit(i == jtag_pkg::IR_WIDTH - 1, bits[0], sampled);
			bits = bits >> 1;
			captured = {sampled, captured[jtag_pkg::IR_WIDTH-1:1]};
		end
		tms_step(1'b1); // update_ir.
		tms_step(1'b0);
	endtask

	task automatic shift_dr(input int width, input logic [31:0] data, output logic [31:0] captured);
		logic [31:0] bits;
		logic        sampled;
		bits = data;
		captured = '0;
		tms_step(1'b1);
		tms_step(1'b0);
		tms_step(1'b0);
		for (int i = 0; i < width; i++) begin
			clock_bit(i == width - 1, bits[0], sampled);
			compare_flag(tdo_en, 1'b1, "tdo_en during shift");
			bits = bits >> 1;
			captured = {sampled, captured[31:1]};
		end
		captured = captured >> (32 - width);
		tms_step(1'b1); // update_dr.
		tms_step(1'b0);
	endtask

	// --------------------
	task automatic test_reset_values();
		apply_reset();
		compare_state(tap_state, jtag_pkg::TEST_LOGIC_RESET);
		compare_instr(instruction, jtag_pkg::INSTR_IDCODE);
		compare_flag(tdo_en, 1'b0, "tdo_en after reset");
		compare_flag(tdo, 1'b0, "tdo after reset");
		compare_flag(user_update, 1'b0, "user_update after reset");
		compare_bits(user_data, '0, "user_data after reset");
	endtask

	task automatic test_random_walk();
		int rnd;
		for (int i = 0; i < 200; i++) begin
			rnd = $random(seed);
			tms_step(rnd[0]);
		end
	endtask

	task automatic test_idcode();
		logic [31:0] cap;
		int          rnd;
		apply_reset();
		tms_step(1'b0);
		rnd = $random(seed);
		shift_dr(32, rnd, cap);
		compare_idcode(cap, TB_IDCODE);
	endtask

	task automatic test_bypass(input logic [jtag_pkg::IR_WIDTH-1:0] code);
		logic [jtag_pkg::IR_WIDTH-1:0] ir_cap;
		logic [31:0]                   cap;
		logic [USER_WIDTH-1:0]         pattern;
		int                            rnd;
		shift_ir(code, ir_cap);
		compare_ir(ir_cap, jtag_pkg::IR_CAPTURE);
		compare_instr(instruction, jtag_pkg::instr_e'(code));
		rnd = $random(seed);
		pattern = rnd[USER_WIDTH-1:0];
		shift_dr(USER_WIDTH, 32'(pattern), cap);
		compare_bits(cap[USER_WIDTH-1:0], {pattern[USER_WIDTH-2:0], 1'b0}, "bypass output");
	endtask

	task automatic test_user_data();
		logic [jtag_pkg::IR_WIDTH-1:0] ir_cap;
		logic [31:0]                   cap;
		logic [USER_WIDTH-1:0]         word;
		int                            rnd;
		shift_ir(jtag_pkg::INSTR_USER_DATA, ir_cap);
		compare_instr(instruction, jtag_pkg::INSTR_USER_DATA);
		rnd = $random(seed);
		word = rnd[USER_WIDTH-1:0];
		pulse_count = 0;
		shift_dr(USER_WIDTH, 32'(word), cap);
		compare_flag(pulse_count == 1, 1'b1, "single user_update pulse");
		compare_bits(user_data, word, "user_data after write");
		shift_dr(USER_WIDTH, 32'(~word), cap);
		compare_bits(cap[USER_WIDTH-1:0], word, "user readback");
		user_expect = ~word;
	endtask

	task automatic test_reset_from_shift();
		logic [jtag_pkg::IR_WIDTH-1:0] ir_cap;
		shift_ir(jtag_pkg::INSTR_BYPASS, ir_cap);
		tms_step(1'b1);
		tms_step(1'b0);
		tms_step(1'b0);
		repeat (5) tms_step(1'b1);
		compare_state(tap_state, jtag_pkg::TEST_LOGIC_RESET);
		tms_step(1'b1); // latch clears while in reset.
		compare_instr(instruction, jtag_pkg::INSTR_IDCODE);
		compare_bits(user_data, user_expect, "user_data after tms reset");
	endtask

	// --------------------
	initial begin
		rst = 1'b1;
		tms = 1'b1;
		tdi = 1'b0;
		pulse_count = 0;
		user_expect = '0;
		model_state = jtag_pkg::TEST_LOGIC_RESET;
		test_reset_values();
		test_random_walk();
		test_idcode();
		test_bypass(jtag_pkg::INSTR_BYPASS);
		test_bypass(4'b0110);
		test_user_data();
		test_reset_from_shift();
		$display("Simulation passed");
		$finish;
	end

endmodule

// File: jtag_tap.f
source/jtag_pkg.sv
source/tap_controller.sv
source/instruction_register.sv
source/data_path.sv
source/jtag_tap.sv
testbench/tap_controller_assertions.sv
testbench/tb_jtag_tap.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the jtag tap testbench with verilator, runs it and scans the log.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_jtag_tap \
	-f jtag_tap.f -o sim_jtag_tap
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_jtag_tap > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Simulation failed" "$LOG"; then
	echo "failure reported in $LOG"
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
echo "no failure found in $LOG"
exit 0
